// File: list.f
design/draw_pkg.sv
design/fb_pkg.sv
design/draw_line.sv
design/draw_triangle.sv
design/pixel_fifo.sv
design/fb_writer.sv
design/triangle_render_top.sv
tests/tb_triangle_render.sv

// File: tests/tb_triangle_render.sv
/* testbench for the triangle outline renderer. draws a table of triangles and checks
   the writes at a random-delay memory responder against a Bresenham reference model */
`default_nettype none
`timescale 1ns/1ps

module tb_triangle_render;

    localparam int CORDW      = 10;
    localparam int FB_WIDTH   = 160;
    localparam int FB_HEIGHT  = 120;
    localparam int ADDRW      = 15;
    localparam int FIFO_DEPTH = 8;
    localparam int NUM_TRI    = 7;

    // x0 y0 x1 y1 x2 y2 colour
    int tri_tab [NUM_TRI][7] = '{
        '{10, 10, 60, 10, 30, 50, 3},      // flat top edge
        '{20, 100, 20, 20, 80, 60, 5},     // vertical edge
        '{100, 5, 110, 115, 90, 60, 9},    // steep edges
        '{150, 30, 200, 40, 140, 90, 12},  // crosses right border
        '{70, 70, 70, 70, 70, 70, 7},      // all vertices equal
        '{30, 110, 50, 130, 10, 125, 2},   // crosses bottom border
        '{5, 119, 159, 0, 80, 119, 15}     // long shallow edges
    };

    logic             clk, rst, start;
    logic [CORDW-1:0] x0, y0, x1, y1, x2, y2;
    fb_pkg::color_t   color;
    logic             mem_ack = 1'b0;
    logic             mem_req, busy, done;
    logic [ADDRW-1:0] mem_addr;
    fb_pkg::color_t   mem_color;

    logic [ADDRW-1:0] exp_addr [$];       // expected writes in order
    fb_pkg::color_t   exp_color [$];
    int               exp_writes [NUM_TRI];  // model writes per triangle
    logic [31:0]      lcg_state = 32'd63192;
    int               cycle_cnt = 0;
    int               cycle_limit = 0;
    int               write_cnt = 0;      // writes of the current triangle
    int               done_cnt = 0;
    int               wait_cnt = 0;       // cycles left before ack
    logic             req_q = 1'b0;       // mem_req one cycle back

    triangle_render_top #(
        .CORDW(CORDW), .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT),
        .ADDRW(ADDRW), .FIFO_DEPTH(FIFO_DEPTH)
    ) i_dut (
        .clk(clk), .rst(rst), .start(start),
        .x0(x0), .y0(y0), .x1(x1), .y1(y1), .x2(x2), .y2(y2),
        .color(color), .mem_ack(mem_ack), .mem_req(mem_req),
        .mem_addr(mem_addr), .mem_color(mem_color), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_addr(input logic [ADDRW-1:0] got, input logic [ADDRW-1:0] exp,
                              input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_color(input fb_pkg::color_t got, input fb_pkg::color_t exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);  // upper bits spread better
    endfunction

    // reference line walk including both endpoints
    task automatic walk_line(input int xa, input int ya, input int xb, input int yb,
                             input fb_pkg::color_t c, inout int n_pix);
        int dx, dy, sx, sy, err, e2, x, y;
        dx = (xb > xa) ? xb - xa : xa - xb;
        dy = (yb > ya) ? ya - yb : yb - ya;  // kept negative
        sx = (xb < xa) ? -1 : 1;
        sy = (yb < ya) ? -1 : 1;
        err = dx + dy;
        x = xa;
        y = ya;
        forever begin
            n_pix++;
            if (x < FB_WIDTH && y < FB_HEIGHT) begin  // clipped pixels skipped
                exp_addr.push_back(ADDRW'(y * FB_WIDTH + x));
                exp_color.push_back(c);
            end
            if (x == xb && y == yb) begin
                break;
            end
            e2 = 2 * err;  // both tests use the old error
            if (e2 >= dy) begin
                err += dy;
                x += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y += sy;
            end
        end
    endtask

    task automatic trace_triangle(input int t, inout int n_pix);
        draw_pkg::edge_t e;
        int a, b;  // vertex indices of the edge
        e = draw_pkg::EDGE_01;
        repeat (3) begin
            case (e)
                draw_pkg::EDGE_01: begin
                    a = 0;
                    b = 1;
                end
                draw_pkg::EDGE_12: begin
                    a = 1;
                    b = 2;
                end
                default: begin
                    a = 2;
                    b = 0;
                end
            endcase
            walk_line(tri_tab[t][2*a], tri_tab[t][2*a+1], tri_tab[t][2*b], tri_tab[t][2*b+1],
                      fb_pkg::color_t'(tri_tab[t][6]), n_pix);
            e = e.next();
        end
    endtask

    // memory responder with random ack delay and write checks
    always @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            req_q   <= 1'b0;
        end else begin
            if (mem_req && !req_q) begin  // new request
                check_flag(mem_ack, 1'b0, "mem_ack when mem_req rises");
                if (exp_addr.size() == 0) begin
                    fail_run("a memory write was requested when no write was expected");
                end
                check_addr(mem_addr, exp_addr.pop_front(), "write address");
                check_color(mem_color, exp_color.pop_front(), "write colour");
                write_cnt++;
                wait_cnt = lcg_next() % 6;  // 0 to 5 cycles
            end
            if (!mem_req && req_q) begin
                check_flag(mem_ack, 1'b1, "mem_ack when mem_req drops");
            end
            if (mem_req && !mem_ack) begin
                if (wait_cnt == 0) begin
                    mem_ack <= 1'b1;
                end else begin
                    wait_cnt--;
                end
            end else if (!mem_req && mem_ack) begin
                mem_ack <= 1'b0;  // phase four
            end
            req_q <= mem_req;
        end
    end

    always @(posedge clk) begin
        if (!rst && done) begin
            done_cnt++;
        end
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            fail_run("timeout: the renderer did not finish within the cycle limit");
        end
    end

    initial begin
        int total_pix;
        int n_exp;
        total_pix = 0;
        for (int t = 0; t < NUM_TRI; t++) begin
            n_exp = exp_addr.size();
            trace_triangle(t, total_pix);
            exp_writes[t] = exp_addr.size() - n_exp;  // pixels left after clipping
        end
        cycle_limit = total_pix * 12 + 200;
        rst   = 1'b1;
        start = 1'b0;
        {x0, y0, x1, y1, x2, y2} = '0;
        color = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        for (int t = 0; t < NUM_TRI; t++) begin
            write_cnt = 0;
            x0 <= CORDW'(tri_tab[t][0]);
            y0 <= CORDW'(tri_tab[t][1]);
            x1 <= CORDW'(tri_tab[t][2]);
            y1 <= CORDW'(tri_tab[t][3]);
            x2 <= CORDW'(tri_tab[t][4]);
            y2 <= CORDW'(tri_tab[t][5]);
            color <= fb_pkg::color_t'(tri_tab[t][6]);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(posedge clk);
            while (!done) begin
                check_flag(busy, 1'b1, "busy while a triangle is in flight");
                @(posedge clk);
            end
            check_flag(mem_ack, 1'b0, "mem_ack at done");
            if (write_cnt != exp_writes[t]) begin
                fail_run($sformatf("[ERROR] %0t: triangle %0d gave %0d writes, expected %0d",
                                   $time, t, write_cnt, exp_writes[t]));
            end
            @(posedge clk);
            check_flag(done, 1'b0, "done one cycle after its pulse");
            check_flag(busy, 1'b0, "busy after done");
        end
        repeat (20) @(posedge clk);  // catch stray pulses
        if (done_cnt == NUM_TRI) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_run($sformatf("[ERROR] %0t: %0d done pulses for %0d triangles",
                               $time, done_cnt, NUM_TRI));
        end
    end

endmodule

`default_nettype wire

// File: design/triangle_render_top.sv
/* triangle outline renderer, producer -> pixel FIFO -> framebuffer writer.
   start is taken only while busy is low, done pulses after the last write */
`default_nettype none
`timescale 1ns/1ps

module triangle_render_top #(
    parameter int CORDW      = draw_pkg::CORDW_DEFAULT,
    parameter int FB_WIDTH   = fb_pkg::FB_WIDTH_DEFAULT,
    parameter int FB_HEIGHT  = fb_pkg::FB_HEIGHT_DEFAULT,
    parameter int ADDRW      = 15,
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,
    input  wire logic [CORDW-1:0] x0,
    input  wire logic [CORDW-1:0] y0,
    input  wire logic [CORDW-1:0] x1,
    input  wire logic [CORDW-1:0] y1,
    input  wire logic [CORDW-1:0] x2,
    input  wire logic [CORDW-1:0] y2,
    input  wire fb_pkg::color_t   color,
    input  wire logic             mem_ack,
    output logic                  mem_req,
    output logic      [ADDRW-1:0] mem_addr,
    output fb_pkg::color_t        mem_color,
    output logic                  busy,
    output logic                  done
);
    logic             start_ok;    // accepted start
    fb_pkg::color_t   color_q;     // colour held for the whole triangle
    logic [CORDW-1:0] px, py;
    logic             pix_valid, pix_last;
    logic             tri_drawing;
    logic [CORDW-1:0] rd_x, rd_y;
    logic             rd_last, not_empty, full, pop;
    logic             wr_active;

    assign start_ok = start && !busy;
    assign busy     = tri_drawing || not_empty || wr_active;

    always_ff @(posedge clk) begin
        if (start_ok) begin
            color_q <= color;
        end
    end

    draw_triangle #(.CORDW(CORDW)) i_draw (
        .clk       (clk),
        .rst       (rst),
        .start     (start_ok),
        .oe        (!full),        // hold the stepper while the FIFO is full
        .x0        (x0),
        .y0        (y0),
        .x1        (x1),
        .y1        (y1),
        .x2        (x2),
        .y2        (y2),
        .px        (px),
        .py        (py),
        .pix_valid (pix_valid),
        .pix_last  (pix_last),
        .drawing   (tri_drawing),
        .tri_done  ()              // completion is taken from the writer
    );

    pixel_fifo #(.CORDW(CORDW), .FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (pix_valid),
        .wr_x      (px),
        .wr_y      (py),
        .wr_last   (pix_last),
        .pop       (pop),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_last   (rd_last),
        .not_empty (not_empty),
        .full      (full)
    );

    fb_writer #(
        .CORDW     (CORDW),
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .ADDRW     (ADDRW)
    ) i_writer (
        .clk       (clk),
        .rst       (rst),
        .not_empty (not_empty),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_last   (rd_last),
        .color     (color_q),
        .mem_ack   (mem_ack),
        .pop       (pop),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_color (mem_color),
        .active    (wr_active),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: design/fb_writer.sv
/* framebuffer writer, clips each pixel, forms y*FB_WIDTH+x and writes it
   to memory over a four-phase req/ack exchange */
`default_nettype none
`timescale 1ns/1ps

module fb_writer #(
    parameter int CORDW     = draw_pkg::CORDW_DEFAULT,    // coordinate width
    parameter int FB_WIDTH  = fb_pkg::FB_WIDTH_DEFAULT,   // pixels per row
    parameter int FB_HEIGHT = fb_pkg::FB_HEIGHT_DEFAULT,  // rows
    parameter int ADDRW     = 15                          // memory address width
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             not_empty,  // head entry valid
    input  wire logic [CORDW-1:0] rd_x,
    input  wire logic [CORDW-1:0] rd_y,
    input  wire logic             rd_last,
    input  wire fb_pkg::color_t   color,      // colour of the current triangle
    input  wire logic             mem_ack,
    output logic                  pop,        // head taken this cycle
    output logic                  mem_req,
    output logic      [ADDRW-1:0] mem_addr,
    output fb_pkg::color_t        mem_color,
    output logic                  active,     // entry in flight
    output logic                  done        // last entry retired
);
    localparam logic [1:0] S_IDLE = 2'd0;  // waiting for an entry
    localparam logic [1:0] S_REQ  = 2'd1;  // req high, waiting for ack
    localparam logic [1:0] S_REL  = 2'd2;  // req low, waiting for ack to drop

    logic [1:0]       state;
    logic             in_fb;
    logic [ADDRW-1:0] addr_calc;
    logic             last_q;  // flag of the entry being written

    assign in_fb     = (rd_x < FB_WIDTH) && (rd_y < FB_HEIGHT);
    assign addr_calc = ADDRW'(rd_y) * ADDRW'(FB_WIDTH) + ADDRW'(rd_x);

    assign pop     = (state == S_IDLE) && not_empty;
    assign mem_req = (state == S_REQ);
    assign active  = (state != S_IDLE) || done;  // covers the done cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (not_empty) begin
                        if (in_fb) begin
                            mem_addr  <= addr_calc;
                            mem_color <= color;
                            last_q    <= rd_last;
                            state     <= S_REQ;
                        end else begin
                            done <= rd_last;  // clipped, retired at once
                        end
                    end
                end
                S_REQ: begin
                    if (mem_ack) begin
                        state <= S_REL;
                    end
                end
                S_REL: begin
                    if (!mem_ack) begin  // exchange complete
                        state <= S_IDLE;
                        done  <= last_q;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/pixel_fifo.sv
/* first-word fall-through FIFO for pixel coordinates and the last flag.
   head is valid while not_empty is high, pop takes it */
`default_nettype none
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int CORDW      = draw_pkg::CORDW_DEFAULT,  // coordinate width
    parameter int FIFO_DEPTH = 8                         // power of two
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             push,
    input  wire logic [CORDW-1:0] wr_x,
    input  wire logic [CORDW-1:0] wr_y,
    input  wire logic             wr_last,
    input  wire logic             pop,
    output logic      [CORDW-1:0] rd_x,       // head entry
    output logic      [CORDW-1:0] rd_y,
    output logic                  rd_last,
    output logic                  not_empty,
    output logic                  full
);
    localparam int PW = $clog2(FIFO_DEPTH);  // pointer width
    localparam int DW = 2 * CORDW + 1;       // last, y, x

    logic [DW-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [PW:0]   count;
    logic          do_push, do_pop;

    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign full      = (count == (PW+1)'(FIFO_DEPTH));
    assign not_empty = (count != '0);

    assign {rd_last, rd_y, rd_x} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {wr_last, wr_y, wr_x};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/draw_triangle.sv
/* triangle outline producer, walks edges 0-1, 1-2 and 2-0 through draw_line.
   pushes one pixel per cycle while oe is high, pix_last marks the final one */
`default_nettype none
`timescale 1ns/1ps

module draw_triangle #(
    parameter int CORDW = draw_pkg::CORDW_DEFAULT  // coordinate width
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,      // taken only when idle
    input  wire logic             oe,         // buffer has room
    input  wire logic [CORDW-1:0] x0,         // vertices
    input  wire logic [CORDW-1:0] y0,
    input  wire logic [CORDW-1:0] x1,
    input  wire logic [CORDW-1:0] y1,
    input  wire logic [CORDW-1:0] x2,
    input  wire logic [CORDW-1:0] y2,
    output logic      [CORDW-1:0] px,         // pixel to push
    output logic      [CORDW-1:0] py,
    output logic                  pix_valid,  // push strobe
    output logic                  pix_last,   // endpoint of the last edge
    output logic                  drawing,    // triangle in progress
    output logic                  tri_done    // one cycle after last edge
);
    localparam logic S_IDLE = 1'b0;
    localparam logic S_DRAW = 1'b1;

    logic                 state;
    draw_pkg::edge_t      cur_edge;
    logic [CORDW-1:0]     vx0, vy0, vx1, vy1, vx2, vy2;  // latched vertices
    logic [CORDW-1:0]     lx0, ly0, lx1, ly1;            // current edge
    logic                 line_start;
    logic                 line_drawing, line_end, line_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            cur_edge   <= draw_pkg::EDGE_01;
            line_start <= 1'b0;
            tri_done   <= 1'b0;
        end else begin
            line_start <= 1'b0;
            tri_done   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        {vx0, vy0} <= {x0, y0};
                        {vx1, vy1} <= {x1, y1};
                        {vx2, vy2} <= {x2, y2};
                        cur_edge   <= draw_pkg::EDGE_01;
                        line_start <= 1'b1;
                        state      <= S_DRAW;
                    end
                end
                default: begin
                    if (line_done) begin
                        case (cur_edge)
                            draw_pkg::EDGE_01: begin
                                cur_edge   <= draw_pkg::EDGE_12;
                                line_start <= 1'b1;
                            end
                            draw_pkg::EDGE_12: begin
                                cur_edge   <= draw_pkg::EDGE_20;
                                line_start <= 1'b1;
                            end
                            default: begin  // third edge finished
                                tri_done <= 1'b1;
                                state    <= S_IDLE;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (cur_edge)
            draw_pkg::EDGE_01: {lx0, ly0, lx1, ly1} = {vx0, vy0, vx1, vy1};
            draw_pkg::EDGE_12: {lx0, ly0, lx1, ly1} = {vx1, vy1, vx2, vy2};
            default:           {lx0, ly0, lx1, ly1} = {vx2, vy2, vx0, vy0};
        endcase
    end

    draw_line #(.CORDW(CORDW)) i_line (
        .clk      (clk),
        .rst      (rst),
        .start    (line_start),
        .oe       (oe),
        .x0       (lx0),
        .y0       (ly0),
        .x1       (lx1),
        .y1       (ly1),
        .x        (px),
        .y        (py),
        .drawing  (line_drawing),
        .line_end (line_end),
        .done     (line_done)
    );

    assign pix_valid = line_drawing && oe;  // stepper advances on the same cycle
    assign pix_last  = line_end && (cur_edge == draw_pkg::EDGE_20);
    assign drawing   = (state == S_DRAW);

endmodule

`default_nettype wire

// File: design/draw_line.sv
/* Bresenham line stepper, one pixel per cycle while oe is high.
   pulse start with the endpoints, x and y are valid while drawing is high */
`default_nettype none
`timescale 1ns/1ps

module draw_line #(
    parameter int CORDW = draw_pkg::CORDW_DEFAULT  // coordinate width
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,     // begin a new line
    input  wire logic             oe,        // output enable, hold when low
    input  wire logic [CORDW-1:0] x0,        // start point
    input  wire logic [CORDW-1:0] y0,
    input  wire logic [CORDW-1:0] x1,        // end point
    input  wire logic [CORDW-1:0] y1,
    output logic      [CORDW-1:0] x,         // current pixel
    output logic      [CORDW-1:0] y,
    output logic                  drawing,   // x and y hold a pixel
    output logic                  line_end,  // current pixel is the endpoint
    output logic                  done       // one cycle after endpoint taken
);
    localparam int EW = CORDW + 3;  // error term width, room for sums

    logic [CORDW-1:0]     adx, ady;      // magnitudes of the new line
    logic signed [EW-1:0] dx_in, dy_in;  // dx positive, dy negative
    logic signed [EW-1:0] dx, dy, err;   // latched terms
    logic signed [EW:0]   e2;            // twice the error
    logic signed [EW-1:0] err_next;
    logic                 step_x, step_y;
    logic                 left, up;      // step directions
    logic [CORDW-1:0]     xe, ye;        // latched endpoint

    always_comb begin
        adx = (x1 >= x0) ? x1 - x0 : x0 - x1;
        ady = (y1 >= y0) ? y1 - y0 : y0 - y1;
        dx_in = $signed(EW'(adx));
        dy_in = -$signed(EW'(ady));
    end

    assign e2     = {err, 1'b0};
    assign step_x = (e2 >= dy);  // move along x
    assign step_y = (e2 <= dx);  // move along y

    always_comb begin
        err_next = err;
        if (step_x) begin
            err_next = err_next + dy;
        end
        if (step_y) begin
            err_next = err_next + dx;
        end
    end

    assign line_end = drawing && (x == xe) && (y == ye);

    always_ff @(posedge clk) begin
        if (rst) begin
            drawing <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (drawing && oe) begin  // current pixel taken
                if (line_end) begin
                    drawing <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    err <= err_next;
                    if (step_x) begin
                        x <= left ? x - 1'b1 : x + 1'b1;
                    end
                    if (step_y) begin
                        y <= up ? y - 1'b1 : y + 1'b1;
                    end
                end
            end else if (start && !drawing) begin
                x       <= x0;  // first pixel is the start point
                y       <= y0;
                xe      <= x1;
                ye      <= y1;
                left    <= (x1 < x0);
                up      <= (y1 < y0);
                dx      <= dx_in;
                dy      <= dy_in;
                err     <= dx_in + dy_in;
                drawing <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fb_pkg.sv
/* framebuffer side definitions, pixel colour and default size */
`default_nettype none

package fb_pkg;

    // one palette index per pixel
    typedef logic [3:0] color_t;

    localparam int FB_WIDTH_DEFAULT  = 160;  // pixels per row
    localparam int FB_HEIGHT_DEFAULT = 120;  // rows

endpackage

`default_nettype wire

// File: design/draw_pkg.sv
/* geometry definitions for the line and triangle steppers,
   also used by the testbench reference model */
`default_nettype none

package draw_pkg;

    // default coordinate width in bits
    localparam int CORDW_DEFAULT = 10;

    // order in which the outline is walked
    typedef enum logic [1:0] {
        EDGE_01,  // vertex 0 to vertex 1
        EDGE_12,  // vertex 1 to vertex 2
        EDGE_20   // vertex 2 back to vertex 0, last edge
    } edge_t;

endpackage

`default_nettype wire
